// File: flist.f
+incdir+logic
+incdir+test
logic/mrd_ctrl_pkg.sv
logic/mrd_data_pkg.sv
logic/mrd_divider_7.sv
logic/mrd_bank_ram.sv
logic/mrd_mem_unit.sv
logic/mrd_butterfly.sv
logic/mrd_pingpong_ctrl.sv
logic/mrd_top.sv
test/mrd_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = mrd_tb
FLIST = flist.f

SIM = obj_dir/V$(TOP)
SOURCES = $(wildcard logic/*.sv logic/*.svh test/*.sv test/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

// File: test/mrd_tb_tasks.svh
// --------------------
// Failure reporting

task automatic report_mismatch(input string msg);
	$display("Fail %0t: %s", $time, msg);
	$display("FAIL: see errors above");
	$fatal(1, "stopped at the first mismatch");
endtask

function automatic string unit_states();
	mrd_ctrl_pkg::mem_state_t s0;
	mrd_ctrl_pkg::mem_state_t s1;
	s0 = mrd_top_inst.g_unit[0].u_mem.state;
	s1 = mrd_top_inst.g_unit[1].u_mem.state;
	return $sformatf("unit 0 in %s, unit 1 in %s", s0.name(), s1.name());
endfunction

task automatic report_failure(input string msg);
	$display("Error at %0t: %s (%s)", $time, msg, unit_states());
	$display("FAIL: see errors above");
	$fatal(1, "stopped on a failure");
endtask

// --------------------
// Compare tasks

task automatic check_beat(input mrd_data_pkg::st_out_t got,
		input mrd_data_pkg::st_out_t exp_beat, input string what);
	if (got !== exp_beat)
		report_mismatch($sformatf("%s: got sop %b eop %b valid %b re %0d im %0d, %s",
			what, got.sop, got.eop, got.valid, got.re, got.im,
			$sformatf("expected sop %b eop %b valid %b re %0d im %0d",
				exp_beat.sop, exp_beat.eop, exp_beat.valid, exp_beat.re, exp_beat.im)));
endtask

task automatic check_ready(input logic got, input logic exp_level, input string what);
	if (got !== exp_level)
		report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp_level));
endtask

// --------------------
// Reference model

// Bypass keeps each sample and sum-diff rewrites pair (j, j+N/2) as (a+b, a-b)
function automatic void model_packet(input mrd_ctrl_pkg::bf_op_t op, input int n,
		input logic signed [`MRD_IN_W-1:0] re [],
		input logic signed [`MRD_IN_W-1:0] im []);
	mrd_data_pkg::st_out_t beat;
	logic signed [`MRD_D_W-1:0] a_re;
	logic signed [`MRD_D_W-1:0] a_im;
	logic signed [`MRD_D_W-1:0] b_re;
	logic signed [`MRD_D_W-1:0] b_im;
	int h;
	int j;
	h = n / 2;
	for (int i = 0; i < n; i++)
	begin
		beat = '0;
		beat.sop = (i == 0);
		beat.eop = (i == n - 1);
		beat.valid = 1'b1;
		j = (i < h) ? i : i - h;
		a_re = re[j];
		a_im = im[j];
		b_re = re[j + h];
		b_im = im[j + h];
		if (op == mrd_ctrl_pkg::op_bypass)
		begin
			beat.re = (i < h) ? a_re : b_re;
			beat.im = (i < h) ? a_im : b_im;
		end
		else if (i < h)
		begin
			beat.re = a_re + b_re;
			beat.im = a_im + b_im;
		end
		else
		begin
			beat.re = a_re - b_re;
			beat.im = a_im - b_im;
		end
		exp_q.push_back(beat);
	end
	exp_len_q.push_back(n);
endfunction

// --------------------
// Driver and capture

task automatic wait_ready();
	int t;
	t = 0;
	while (in_ready !== 1'b1 && t < WAIT_LIMIT)
	begin
		@(negedge clk);
		t++;
	end
	if (in_ready !== 1'b1)
		report_failure("timed out waiting for in_ready");
endtask

task automatic send_packet(input mrd_ctrl_pkg::bf_op_t op, input int n);
	logic signed [`MRD_IN_W-1:0] re [];
	logic signed [`MRD_IN_W-1:0] im [];
	logic [31:0] rnd;
	re = new[n];
	im = new[n];
	for (int i = 0; i < n; i++)
	begin
		rnd = $random(seed);
		re[i] = rnd[`MRD_IN_W-1:0];
		rnd = $random(seed);
		im[i] = rnd[`MRD_IN_W-1:0];
	end
	model_packet(op, n, re, im);
	wait_ready();
	for (int i = 0; i < n; i++)
	begin
		in_beat = '0;
		in_beat.valid = 1'b1;
		in_beat.sop = (i == 0);
		in_beat.eop = (i == n - 1);
		// Header fields ride on the sop beat only
		if (i == 0)
		begin
			in_beat.op = op;
			in_beat.dftpts = n[`MRD_PTS_W-1:0];
		end
		in_beat.re = re[i];
		in_beat.im = im[i];
		@(negedge clk);
	end
	in_beat = '0;
endtask

task automatic receive_packets(input int count);
	mrd_data_pkg::st_out_t exp_beat;
	int n;
	int t;
	for (int p = 0; p < count; p++)
	begin
		t = 0;
		while (!(out_beat.valid && out_beat.sop) && t < WAIT_LIMIT)
		begin
			check_beat(out_beat, '0, "output between packets");
			@(negedge clk);
			t++;
		end
		if (!(out_beat.valid && out_beat.sop))
			report_failure("timed out waiting for out.sop");
		if (exp_len_q.size() == 0)
			report_failure("a packet came out while none was expected");
		n = exp_len_q.pop_front();
		for (int i = 0; i < n; i++)
		begin
			if (i > 0)
				@(negedge clk);
			exp_beat = exp_q.pop_front();
			check_beat(out_beat, exp_beat,
				$sformatf("packet %0d of %0d points, beat %0d", p, n, i));
		end
		@(negedge clk);
	end
endtask

// --------------------
// Directed tests

task automatic test_reset_levels();
	$display("Test: levels after reset");
	repeat (5)
	begin
		check_ready(in_ready, 1'b1, "in_ready after reset");
		check_ready(out_beat.valid, 1'b0, "out.valid after reset");
		@(negedge clk);
	end
endtask

task automatic test_bypass_8();
	$display("Test: bypass, 8 points");
	fork
		send_packet(mrd_ctrl_pkg::op_bypass, 8);
		receive_packets(1);
	join
endtask

task automatic test_sum_diff_30();
	$display("Test: sum-diff, 30 points");
	fork
		send_packet(mrd_ctrl_pkg::op_sum_diff, 30);
		receive_packets(1);
	join
endtask

// Second sop follows the first eop directly, so both units and the engine are busy
task automatic test_back_to_back();
	$display("Test: back to back packets");
	fork
		begin
			send_packet(mrd_ctrl_pkg::op_sum_diff, 16);
			send_packet(mrd_ctrl_pkg::op_bypass, 64);
		end
		receive_packets(2);
	join
endtask

task automatic test_random_packets();
	int legal_n [14] = '{4, 6, 8, 10, 12, 16, 20, 24, 30, 32, 48, 64, 100, 128};
	logic [31:0] rnd;
	mrd_ctrl_pkg::bf_op_t op;
	int n;
	$display("Test: six random packets");
	fork
		begin
			for (int k = 0; k < 6; k++)
			begin
				rnd = $random(seed);
				n = legal_n[rnd[7:0] % 14];
				rnd = $random(seed);
				op = rnd[0] ? mrd_ctrl_pkg::op_sum_diff : mrd_ctrl_pkg::op_bypass;
				send_packet(op, n);
			end
		end
		receive_packets(6);
	join
endtask

// No extra beat may leave once every packet is out
task automatic test_quiet_after_traffic();
	$display("Test: quiet output after the last packet");
	repeat (20)
	begin
		check_beat(out_beat, '0, "output after the last packet");
		check_ready(in_ready, 1'b1, "in_ready after the last packet");
		@(negedge clk);
	end
endtask

// File: test/mrd_tb.sv
`timescale 1ns/1ps
`include "mrd_settings.svh"

module mrd_tb;

	localparam int WAIT_LIMIT = 5000;

	logic clk;
	logic rst_n;
	mrd_data_pkg::st_in_t in_beat;
	logic in_ready;
	mrd_data_pkg::st_out_t out_beat;

	// Expected output beats of pending packets in arrival order
	mrd_data_pkg::st_out_t exp_q [$];
	int exp_len_q [$];
	integer seed;

	mrd_top mrd_top_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (in_beat),
		.in_ready (in_ready),
		.out      (out_beat)
	);

	always #5 clk = ~clk;

	`include "mrd_tb_tasks.svh"

	// --------------------
	// Test sequence
	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_beat = '0;
		seed = 32'hb0505b34;

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_reset_levels();
		test_bypass_8();
		test_sum_diff_30();
		test_back_to_back();
		test_random_packets();
		test_quiet_after_traffic();

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: logic/mrd_top.sv
`timescale 1ns/1ps

module mrd_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mrd_data_pkg::st_in_t  in,
	output logic                  in_ready,
	output mrd_data_pkg::st_out_t out
);

	logic sink_sel;
	logic [1:0] unit_sel;
	logic [1:0] unit_idle;
	logic [1:0] eng_req;
	logic [1:0] eng_grant;
	logic [1:0] src_req;
	logic [1:0] src_grant;
	logic [1:0] src_done;
	mrd_data_pkg::bf_req_t unit_bf_req [2];
	mrd_data_pkg::bf_req_t bf_req;
	mrd_data_pkg::bf_rsp_t bf_rsp;
	mrd_data_pkg::st_out_t unit_out [2];

	// sop goes to sink_sel
	// later beats belong to the unit that took the last sop
	assign unit_sel = (in.sop ^ sink_sel) ? 2'b01 : 2'b10;

	for (genvar u = 0; u < 2; u++)
	begin : g_unit
		mrd_data_pkg::st_in_t u_in;

		always_comb
		begin
			u_in = in;
			u_in.valid = in.valid && unit_sel[u];
			u_in.sop = in.sop && unit_sel[u];
		end

		mrd_mem_unit u_mem (
			.clk       (clk),
			.rst_n     (rst_n),
			.in        (u_in),
			.eng_req   (eng_req[u]),
			.eng_grant (eng_grant[u]),
			.bf_req    (unit_bf_req[u]),
			.bf_rsp    (bf_rsp),
			.src_req   (src_req[u]),
			.src_grant (src_grant[u]),
			.src_done  (src_done[u]),
			.out       (unit_out[u]),
			.idle      (unit_idle[u])
		);
	end

	assign bf_req = eng_grant[1] ? unit_bf_req[1] : (eng_grant[0] ? unit_bf_req[0] : '0);

	mrd_butterfly u_bf (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (bf_req),
		.rsp   (bf_rsp)
	);

	mrd_pingpong_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.sop       (in.valid && in.sop),
		.unit_idle (unit_idle),
		.in_ready  (in_ready),
		.sink_sel  (sink_sel),
		.eng_req   (eng_req),
		.eng_grant (eng_grant),
		.src_req   (src_req),
		.src_done  (src_done),
		.src_grant (src_grant)
	);

	// Idle units drive zeros
	assign out = unit_out[0] | unit_out[1];

endmodule

// File: logic/mrd_pingpong_ctrl.sv
`timescale 1ns/1ps

module mrd_pingpong_ctrl (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       sop,
	input  logic [1:0] unit_idle,
	output logic       in_ready,
	output logic       sink_sel,
	input  logic [1:0] eng_req,
	output logic [1:0] eng_grant,
	input  logic [1:0] src_req,
	input  logic [1:0] src_done,
	output logic [1:0] src_grant
);

	logic last_eng;
	logic token;
	logic [1:0] token_hot;

	assign in_ready = unit_idle[sink_sel];
	assign token_hot = token ? 2'b10 : 2'b01;

	// --------------------
	// Sink pointer
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			sink_sel <= 1'b0;
		else if (sop && in_ready)
			sink_sel <= ~sink_sel;
	end

	// --------------------
	// Engine arbiter that holds a grant while its request stays up
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			eng_grant <= 2'b00;
			last_eng <= 1'b0;
		end
		else if ((eng_grant & eng_req) == 2'b00)
		begin
			if (eng_req == 2'b11)
			begin
				eng_grant <= last_eng ? 2'b01 : 2'b10;
				last_eng <= ~last_eng;
			end
			else
			begin
				eng_grant <= eng_req;
				if (eng_req != 2'b00)
					last_eng <= eng_req[1];
			end
		end
	end

	// --------------------
	// Source token keeps packets in arrival order
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			token <= 1'b0;
			src_grant <= 2'b00;
		end
		else
		begin
			src_grant <= src_req & token_hot;
			if ((src_done & token_hot) != 2'b00)
				token <= ~token;
		end
	end

endmodule

// File: logic/mrd_butterfly.sv
`timescale 1ns/1ps

module mrd_butterfly (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mrd_data_pkg::bf_req_t req,
	output mrd_data_pkg::bf_rsp_t rsp
);

	always_ff @(posedge clk)
	begin
		// Targets ride along with the data
		rsp.a_bank <= req.a_bank;
		rsp.a_row <= req.a_row;
		rsp.b_bank <= req.b_bank;
		rsp.b_row <= req.b_row;
		if (req.op == mrd_ctrl_pkg::op_sum_diff)
		begin
			rsp.a.re <= req.a.re + req.b.re;
			rsp.a.im <= req.a.im + req.b.im;
			rsp.b.re <= req.a.re - req.b.re;
			rsp.b.im <= req.a.im - req.b.im;
		end
		else
		begin
			rsp.a <= req.a;
			rsp.b <= req.b;
		end
		if (!rst_n)
			rsp.valid <= 1'b0;
		else
			rsp.valid <= req.valid;
	end

endmodule

// File: logic/mrd_mem_unit.sv
`timescale 1ns/1ps
`include "mrd_settings.svh"

module mrd_mem_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  mrd_data_pkg::st_in_t  in,
	output logic                  eng_req,
	input  logic                  eng_grant,
	output mrd_data_pkg::bf_req_t bf_req,
	input  mrd_data_pkg::bf_rsp_t bf_rsp,
	output logic                  src_req,
	input  logic                  src_grant,
	output logic                  src_done,
	output mrd_data_pkg::st_out_t out,
	output logic                  idle
);

	localparam int NB = `MRD_NBANK;
	localparam int PW = `MRD_PTS_W;
	localparam int XW = `MRD_D_W - `MRD_IN_W;

	mrd_ctrl_pkg::mem_state_t state;
	mrd_ctrl_pkg::bf_op_t op;
	logic [PW-1:0] n_pts;
	logic [PW-1:0] half;

	logic accept;
	logic [PW-1:0] sink_cnt;
	logic s1_valid;
	logic s1_eop;
	logic [PW-1:0] s1_idx;
	mrd_data_pkg::cplx_t s1_data;
	mrd_data_pkg::row_t sink_row;
	mrd_data_pkg::bank_t sink_bank;
	logic s2_valid;
	mrd_data_pkg::row_t s2_row;
	mrd_data_pkg::bank_t s2_bank;
	mrd_data_pkg::cplx_t s2_data;

	logic rd_go;
	logic [PW-1:0] pair_cnt;
	mrd_data_pkg::bank_t a_bank;
	mrd_data_pkg::row_t a_row;
	mrd_data_pkg::bank_t b_bank;
	mrd_data_pkg::row_t b_row;
	logic r1_valid;
	mrd_data_pkg::bank_t r1_a_bank;
	mrd_data_pkg::row_t r1_a_row;
	mrd_data_pkg::bank_t r1_b_bank;
	mrd_data_pkg::row_t r1_b_row;
	mrd_data_pkg::bf_rsp_t wr;
	logic [PW-1:0] wr_cnt;

	logic src_rd;
	logic [PW-1:0] src_cnt;
	mrd_data_pkg::row_t src_row;
	mrd_data_pkg::bank_t src_bank;
	mrd_data_pkg::bank_t src_bank_r;
	logic src_vld_r;
	logic src_sop_r;
	logic src_eop_r;

	logic [NB-1:0] s2_hot;
	logic [NB-1:0] rd_a_hot;
	logic [NB-1:0] rd_b_hot;
	logic [NB-1:0] wr_a_hot;
	logic [NB-1:0] wr_b_hot;
	logic [NB-1:0] src_hot;
	mrd_data_pkg::cplx_t dout [NB];

	function automatic logic [NB-1:0] bank_hot(input mrd_data_pkg::bank_t b);
		logic [NB-1:0] v;
		v = '0;
		v[b] = 1'b1;
		return v;
	endfunction

	assign idle = (state == mrd_ctrl_pkg::idle);
	assign eng_req = (state == mrd_ctrl_pkg::rd) || (state == mrd_ctrl_pkg::wait_wr_end);
	assign src_req = (state == mrd_ctrl_pkg::source);
	assign accept = in.valid && ((state == mrd_ctrl_pkg::sink) || (idle && in.sop));

	// --------------------
	// FSM
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= mrd_ctrl_pkg::idle;
		else
		begin
			case (state)
			mrd_ctrl_pkg::idle:
				if (accept)
					state <= mrd_ctrl_pkg::sink;
			mrd_ctrl_pkg::sink:
				if (s1_valid && s1_eop)
					state <= mrd_ctrl_pkg::rd;
			mrd_ctrl_pkg::rd:
				if (rd_go && pair_cnt == half - 1'b1)
					state <= mrd_ctrl_pkg::wait_wr_end;
			mrd_ctrl_pkg::wait_wr_end:
				if (wr.valid && wr_cnt == half - 1'b1)
					state <= mrd_ctrl_pkg::source;
			mrd_ctrl_pkg::source:
				if (src_eop_r)
					state <= mrd_ctrl_pkg::idle;
			default:
				state <= mrd_ctrl_pkg::idle;
			endcase
		end
	end

	// Packet header
	always_ff @(posedge clk)
	begin
		if (idle && accept)
		begin
			n_pts <= in.dftpts;
			half <= in.dftpts >> 1;
			op <= in.op;
		end
	end

	// --------------------
	// Sink through the input register and the divider register into the banks
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			sink_cnt <= '0;
		end
		else
		begin
			s1_valid <= accept;
			s2_valid <= s1_valid;
			if (accept)
				sink_cnt <= in.sop ? PW'(1) : sink_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_idx <= in.sop ? '0 : sink_cnt;
		s1_eop <= in.eop;
		s1_data.re <= {{XW{in.re[`MRD_IN_W-1]}}, in.re};
		s1_data.im <= {{XW{in.im[`MRD_IN_W-1]}}, in.im};
		s2_row <= sink_row;
		s2_bank <= sink_bank;
		s2_data <= s1_data;
	end

	mrd_divider_7 u_div_sink (
		.index (s1_idx),
		.row   (sink_row),
		.bank  (sink_bank)
	);

	// --------------------
	// Pair read with j from running counters and j+N/2 through the divider
	assign rd_go = (state == mrd_ctrl_pkg::rd) && eng_grant;

	mrd_divider_7 u_div_pair (
		.index (pair_cnt + half),
		.row   (b_row),
		.bank  (b_bank)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pair_cnt <= '0;
			a_bank <= '0;
			a_row <= '0;
			r1_valid <= 1'b0;
			wr_cnt <= '0;
		end
		else
		begin
			r1_valid <= rd_go;
			if (state == mrd_ctrl_pkg::sink)
			begin
				pair_cnt <= '0;
				a_bank <= '0;
				a_row <= '0;
				wr_cnt <= '0;
			end
			else
			begin
				wr_cnt <= wr_cnt + PW'(wr.valid);
				if (rd_go)
				begin
					pair_cnt <= pair_cnt + 1'b1;
					a_bank <= (a_bank == 3'd6) ? '0 : a_bank + 1'b1;
					a_row <= (a_bank == 3'd6) ? a_row + 1'b1 : a_row;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		r1_a_bank <= a_bank;
		r1_a_row <= a_row;
		r1_b_bank <= b_bank;
		r1_b_row <= b_row;
		bf_req.op <= op;
		bf_req.a <= dout[r1_a_bank];
		bf_req.b <= dout[r1_b_bank];
		bf_req.a_bank <= r1_a_bank;
		bf_req.a_row <= r1_a_row;
		bf_req.b_bank <= r1_b_bank;
		bf_req.b_row <= r1_b_row;
		if (!rst_n)
			bf_req.valid <= 1'b0;
		else
			bf_req.valid <= r1_valid;
	end

	// Write-back stage where only the granted unit takes the response
	always_ff @(posedge clk)
	begin
		wr <= bf_rsp;
		if (!rst_n)
			wr.valid <= 1'b0;
		else
			wr.valid <= bf_rsp.valid && eng_grant && eng_req;
	end

	// --------------------
	// Source in natural order
	assign src_rd = src_req && src_grant && (src_cnt != n_pts);

	mrd_divider_7 u_div_src (
		.index (src_cnt),
		.row   (src_row),
		.bank  (src_bank)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			src_cnt <= '0;
			src_vld_r <= 1'b0;
			src_sop_r <= 1'b0;
			src_eop_r <= 1'b0;
			src_done <= 1'b0;
		end
		else
		begin
			src_cnt <= (state == mrd_ctrl_pkg::sink) ? '0 : src_cnt + PW'(src_rd);
			src_vld_r <= src_rd;
			src_sop_r <= src_rd && (src_cnt == '0);
			src_eop_r <= src_rd && (src_cnt == n_pts - 1'b1);
			src_done <= src_eop_r;
		end
	end

	always_ff @(posedge clk)
	begin
		src_bank_r <= src_bank;
	end

	always_comb
	begin
		out = '0;
		if (src_vld_r)
		begin
			out.sop = src_sop_r;
			out.eop = src_eop_r;
			out.valid = 1'b1;
			out.re = dout[src_bank_r].re;
			out.im = dout[src_bank_r].im;
		end
	end

	// --------------------
	// Seven banks
	assign s2_hot = bank_hot(s2_bank);
	assign rd_a_hot = bank_hot(a_bank);
	assign rd_b_hot = bank_hot(b_bank);
	assign wr_a_hot = bank_hot(wr.a_bank);
	assign wr_b_hot = bank_hot(wr.b_bank);
	assign src_hot = bank_hot(src_bank);

	for (genvar k = 0; k < NB; k++)
	begin : g_bank
		logic wren;
		logic rden;
		mrd_data_pkg::row_t wraddr;
		mrd_data_pkg::row_t rdaddr;
		mrd_data_pkg::cplx_t din;

		always_comb
		begin
			// Sink writes and write-back never overlap in time
			if (s2_valid)
			begin
				wren = s2_hot[k];
				wraddr = s2_row;
				din = s2_data;
			end
			else
			begin
				wren = wr.valid && (wr_a_hot[k] || wr_b_hot[k]);
				wraddr = wr_a_hot[k] ? wr.a_row : wr.b_row;
				din = wr_a_hot[k] ? wr.a : wr.b;
			end
			if (state == mrd_ctrl_pkg::rd)
			begin
				rden = rd_go && (rd_a_hot[k] || rd_b_hot[k]);
				rdaddr = rd_a_hot[k] ? a_row : b_row;
			end
			else
			begin
				rden = src_rd && src_hot[k];
				rdaddr = src_row;
			end
		end

		mrd_bank_ram u_ram (
			.clk    (clk),
			.wren   (wren),
			.wraddr (wraddr),
			.din    (din),
			.rden   (rden),
			.rdaddr (rdaddr),
			.dout   (dout[k])
		);
	end

endmodule

// File: logic/mrd_bank_ram.sv
`timescale 1ns/1ps
`include "mrd_settings.svh"

module mrd_bank_ram (
	input  logic                clk,
	input  logic                wren,
	input  mrd_data_pkg::row_t  wraddr,
	input  mrd_data_pkg::cplx_t din,
	input  logic                rden,
	input  mrd_data_pkg::row_t  rdaddr,
	output mrd_data_pkg::cplx_t dout
);

	localparam int DEPTH = 1 << `MRD_ROW_W;

	mrd_data_pkg::cplx_t mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wren)
			mem[wraddr] <= din;
		// Registered read
		if (rden)
			dout <= mem[rdaddr];
	end

endmodule

// File: logic/mrd_divider_7.sv
`timescale 1ns/1ps
`include "mrd_settings.svh"

module mrd_divider_7 (
	input  logic [`MRD_PTS_W-1:0] index,
	output mrd_data_pkg::row_t    row,
	output mrd_data_pkg::bank_t   bank
);

	logic [`MRD_PTS_W-1:0] quo;
	logic [3:0] rem;

	// Restoring long division with one index bit per step
	always_comb
	begin
		rem = '0;
		quo = '0;
		for (int i = `MRD_PTS_W - 1; i >= 0; i--)
		begin
			rem = {rem[2:0], index[i]};
			if (rem >= 4'd7)
			begin
				rem = rem - 4'd7;
				quo[i] = 1'b1;
			end
		end
	end

	// Legal indices stay below MRD_MAX_PTS so the row fits
	assign row = quo[`MRD_ROW_W-1:0];
	assign bank = rem[2:0];

endmodule

// File: logic/mrd_data_pkg.sv
`include "mrd_settings.svh"

package mrd_data_pkg;

	typedef logic [$clog2(`MRD_NBANK)-1:0] bank_t;
	typedef logic [`MRD_ROW_W-1:0] row_t;

	// One stored complex word
	typedef struct packed {
		logic signed [`MRD_D_W-1:0] re;
		logic signed [`MRD_D_W-1:0] im;
	} cplx_t;

	// Input beat
	// op and dftpts only count on the sop beat
	typedef struct packed {
		logic sop;
		logic eop;
		logic valid;
		mrd_ctrl_pkg::bf_op_t op;
		logic [`MRD_PTS_W-1:0] dftpts;
		logic signed [`MRD_IN_W-1:0] re;
		logic signed [`MRD_IN_W-1:0] im;
	} st_in_t;

	typedef struct packed {
		logic sop;
		logic eop;
		logic valid;
		logic signed [`MRD_D_W-1:0] re;
		logic signed [`MRD_D_W-1:0] im;
	} st_out_t;

	// Pair sent to the engine, with its write-back targets
	typedef struct packed {
		logic valid;
		mrd_ctrl_pkg::bf_op_t op;
		cplx_t a;
		cplx_t b;
		bank_t a_bank;
		row_t a_row;
		bank_t b_bank;
		row_t b_row;
	} bf_req_t;

	typedef struct packed {
		logic valid;
		cplx_t a;
		cplx_t b;
		bank_t a_bank;
		row_t a_row;
		bank_t b_bank;
		row_t b_row;
	} bf_rsp_t;

endpackage

// File: logic/mrd_ctrl_pkg.sv
package mrd_ctrl_pkg;

	// Memory unit phases
	typedef enum logic [2:0] {
		idle,
		sink,
		rd,
		wait_wr_end,
		source
	} mem_state_t;

	// Butterfly operation taken from the packet at sop
	typedef enum logic {
		op_bypass,
		op_sum_diff
	} bf_op_t;

endpackage

// File: logic/mrd_settings.svh
`ifndef MRD_SETTINGS_SVH
`define MRD_SETTINGS_SVH

// Sample widths
`define MRD_IN_W 18
`define MRD_D_W 30

// Bank layout
`define MRD_NBANK 7
`define MRD_ROW_W 8

// Point counts
`define MRD_PTS_W 12
`define MRD_MAX_PTS 1024

`endif
